/* logic/isram_defs.svh */
`ifndef ISRAM_DEFS_SVH
`define ISRAM_DEFS_SVH

// axi-lite bus widths
`define ISRAM_ADDR_W 32
`define ISRAM_DATA_W 32
// one strobe bit per data byte
`define ISRAM_STRB_W 4

// memory geometry in 32-bit words
`define ISRAM_DEPTH 1024
// log2 of the depth
`define ISRAM_IDX_W 10

// addi x0, x0, 0
`define ISRAM_INST_NOP 32'h0000_0013

// axi response codes
`define ISRAM_RESP_OKAY 2'b00
`define ISRAM_RESP_SLVERR 2'b10

`endif

/* logic/isram_pkg.sv */
`default_nettype none

`include "isram_defs.svh"

package isram_pkg;

    // one access on the single array port
    // we low means a read of idx
    typedef struct packed {
        logic                       we;
        logic [`ISRAM_IDX_W-1:0]    idx;
        logic [`ISRAM_DATA_W-1:0]   wdata;
        logic [`ISRAM_STRB_W-1:0]   strb;
    } sram_req_t;

    // R channel payload
    typedef struct packed {
        logic [`ISRAM_DATA_W-1:0]   data;
        logic [1:0]                 resp;
    } r_payload_t;

    // B channel payload, response code only
    typedef struct packed {
        logic [1:0]                 resp;
    } b_payload_t;

endpackage

`default_nettype wire

/* logic/sram_array.sv */
`timescale 1ns/1ns
`default_nettype none

`include "isram_defs.svh"

module sram_array (
    input  wire logic                       clk,
    // one access per cycle, qualified by req_en
    input  wire isram_pkg::sram_req_t       req,
    input  wire logic                       req_en,
    // word from the last granted read
    output logic [`ISRAM_DATA_W-1:0]        rdata
);

    // word storage, contents undefined until written
    logic [`ISRAM_DATA_W-1:0] mem [`ISRAM_DEPTH];

    // strobed write, one byte lane per strobe bit
    always_ff @(posedge clk) begin
        if (req_en && req.we) begin
            for (int b = 0; b < `ISRAM_STRB_W; b++) begin
                if (req.strb[b]) begin
                    mem[req.idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    // registered read port
    // data shows up the cycle after the request
    // and holds until the next read
    always_ff @(posedge clk) begin
        if (req_en && !req.we) begin
            rdata <= mem[req.idx];
        end
    end

endmodule

`default_nettype wire

/* logic/wait_lfsr.sv */
`timescale 1ns/1ns
`default_nettype none

`include "isram_defs.svh"

module wait_lfsr (
    input  wire logic       clk,
    input  wire logic       rst_n,
    // pseudo-random delay for the next read
    output logic [2:0]      wait_cnt
);

    // any nonzero seed works, all-zero would lock up
    localparam logic [15:0] SEED = 16'hace1;

    logic [15:0] lfsr;
    logic        fb;

    // taps 16,14,13,11, maximal length
    assign fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    // free running, shifts every cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= SEED;
        end else begin
            lfsr <= {lfsr[14:0], fb};
        end
    end

    // low bits as the delay
    // the read controller samples them at AR accept
    assign wait_cnt = lfsr[2:0];

endmodule

`default_nettype wire

/* logic/resp_slot.sv */
`timescale 1ns/1ns
`default_nettype none

`include "isram_defs.svh"

module resp_slot #(
    parameter type payload_t = logic
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    // producer side
    input  wire logic       load,
    input  wire payload_t   load_data,
    output logic            busy,
    // channel side, valid/ready
    output logic            valid,
    input  wire logic       ready,
    output payload_t        data
);

    // valid flag
    // producer only loads while empty, so load never meets a clear
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end else if (valid && ready) begin
            valid <= 1'b0;
        end
    end

    // payload capture
    // held untouched while waiting on ready
    always_ff @(posedge clk) begin
        if (load) begin
            data <= load_data;
        end
    end

    // full slot stalls the producer
    assign busy = valid;

endmodule

`default_nettype wire

/* logic/isram_rd_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "isram_defs.svh"

module isram_rd_ctrl (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    // AR channel
    input  wire logic [`ISRAM_ADDR_W-1:0]   araddr,
    input  wire logic                       arvalid,
    output logic                            arready,
    // delay sample from the lfsr
    input  wire logic [2:0]                 wait_cnt,
    // array port request
    output isram_pkg::sram_req_t            req,
    output logic                            req_en,
    input  wire logic                       grant,
    input  wire logic [`ISRAM_DATA_W-1:0]   sram_rdata,
    // R slot
    output logic                            resp_load,
    output isram_pkg::r_payload_t           resp,
    input  wire logic                       resp_busy
);

    localparam logic [1:0] IDLE   = 2'b00;
    localparam logic [1:0] ACCESS = 2'b01;
    localparam logic [1:0] WAIT   = 2'b10;
    localparam logic [1:0] READ   = 2'b11;

    logic [1:0]               state;
    logic [1:0]               next_state;
    logic [2:0]               cnt_q;
    logic                     err_q;
    logic                     loaded_q;
    logic [`ISRAM_IDX_W-1:0]  idx_q;
    logic                     ar_hs;
    logic                     ar_err;

    // only one read in flight
    assign arready = (state == IDLE);
    assign ar_hs   = arvalid && arready;
    // any upper bit set means past the end of memory
    assign ar_err  = |araddr[`ISRAM_ADDR_W-1:`ISRAM_IDX_W+2];

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (ar_hs) begin
                    // zero delay skips WAIT
                    if (wait_cnt != 3'd0) begin
                        next_state = WAIT;
                    end else begin
                        next_state = ar_err ? READ : ACCESS;
                    end
                end
            end
            WAIT: begin
                // last wait cycle
                if (cnt_q == 3'd1) begin
                    next_state = err_q ? READ : ACCESS;
                end
            end
            ACCESS: begin
                // write side may hold the port
                if (grant) begin
                    next_state = READ;
                end
            end
            READ: begin
                // stay until the R transfer is done
                if (loaded_q && !resp_busy) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            cnt_q    <= 3'd0;
            err_q    <= 1'b0;
            loaded_q <= 1'b0;
        end else begin
            state <= next_state;
            if (ar_hs) begin
                cnt_q <= wait_cnt;
                err_q <= ar_err;
            end else if (state == WAIT) begin
                cnt_q <= cnt_q - 3'd1;
            end
            // one load per read
            if (resp_load) begin
                loaded_q <= 1'b1;
            end else if (state == READ && next_state == IDLE) begin
                loaded_q <= 1'b0;
            end
        end
    end

    // word index, low two address bits dropped
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            idx_q <= araddr[`ISRAM_IDX_W+1:2];
        end
    end

    // read request, held until granted
    always_comb begin
        req_en    = (state == ACCESS);
        req.we    = 1'b0;
        req.idx   = idx_q;
        req.wdata = '0;
        req.strb  = '0;
    end

    // array data is valid on READ entry
    assign resp_load = (state == READ) && !loaded_q && !resp_busy;
    assign resp.data = err_q ? `ISRAM_INST_NOP : sram_rdata;
    assign resp.resp = err_q ? `ISRAM_RESP_SLVERR : `ISRAM_RESP_OKAY;

endmodule

`default_nettype wire

/* logic/isram_wr_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "isram_defs.svh"

module isram_wr_ctrl (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    // AW channel
    input  wire logic [`ISRAM_ADDR_W-1:0]   awaddr,
    input  wire logic                       awvalid,
    output logic                            awready,
    // W channel
    input  wire logic [`ISRAM_DATA_W-1:0]   wdata,
    input  wire logic [`ISRAM_STRB_W-1:0]   wstrb,
    input  wire logic                       wvalid,
    output logic                            wready,
    // array port request
    output isram_pkg::sram_req_t            req,
    output logic                            req_en,
    // B slot
    output logic                            resp_load,
    output isram_pkg::b_payload_t           resp,
    input  wire logic                       resp_busy
);

    logic live_q;
    logic accept;
    logic aw_err;

    // low through reset
    // keeps a write from reaching the array
    // while the B slot is still being cleared
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            live_q <= 1'b0;
        end else begin
            live_q <= 1'b1;
        end
    end

    // address and data taken in the same cycle
    // a full B slot blocks acceptance
    assign accept  = live_q && awvalid && wvalid && !resp_busy;
    assign awready = accept;
    assign wready  = accept;

    // past the end of memory
    assign aw_err = |awaddr[`ISRAM_ADDR_W-1:`ISRAM_IDX_W+2];

    // array write in the accept cycle
    // out of range never touches the array
    always_comb begin
        req_en    = accept && !aw_err;
        req.we    = 1'b1;
        req.idx   = awaddr[`ISRAM_IDX_W+1:2];
        req.wdata = wdata;
        req.strb  = wstrb;
    end

    // response lands in the slot, bvalid next cycle
    assign resp_load = accept;
    assign resp.resp = aw_err ? `ISRAM_RESP_SLVERR : `ISRAM_RESP_OKAY;

endmodule

`default_nettype wire

/* logic/isram_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "isram_defs.svh"

module isram_top (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    // AR
    input  wire logic [`ISRAM_ADDR_W-1:0]   araddr,
    input  wire logic                       arvalid,
    output logic                            arready,
    // R
    output logic [`ISRAM_DATA_W-1:0]        rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  wire logic                       rready,
    // AW
    input  wire logic [`ISRAM_ADDR_W-1:0]   awaddr,
    input  wire logic                       awvalid,
    output logic                            awready,
    // W
    input  wire logic [`ISRAM_DATA_W-1:0]   wdata,
    input  wire logic [`ISRAM_STRB_W-1:0]   wstrb,
    input  wire logic                       wvalid,
    output logic                            wready,
    // B
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  wire logic                       bready
);

    isram_pkg::sram_req_t   rd_req;
    isram_pkg::sram_req_t   wr_req;
    isram_pkg::sram_req_t   arr_req;
    logic                   rd_req_en;
    logic                   wr_req_en;
    logic                   arr_req_en;
    logic                   rd_grant;
    logic [`ISRAM_DATA_W-1:0] sram_rdata;
    logic [2:0]             wait_cnt;

    isram_pkg::r_payload_t  r_load_data;
    isram_pkg::r_payload_t  r_data;
    logic                   r_load;
    logic                   r_busy;
    isram_pkg::b_payload_t  b_load_data;
    isram_pkg::b_payload_t  b_data;
    logic                   b_load;
    logic                   b_busy;

    // single array port, write side first
    assign arr_req    = wr_req_en ? wr_req : rd_req;
    assign arr_req_en = wr_req_en || rd_req_en;
    // read goes through only in a write-free cycle
    assign rd_grant   = rd_req_en && !wr_req_en;

    sram_array sram_array_i (
        .clk    (clk),
        .req    (arr_req),
        .req_en (arr_req_en),
        .rdata  (sram_rdata)
    );

    wait_lfsr wait_lfsr_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wait_cnt (wait_cnt)
    );

    isram_rd_ctrl isram_rd_ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .wait_cnt   (wait_cnt),
        .req        (rd_req),
        .req_en     (rd_req_en),
        .grant      (rd_grant),
        .sram_rdata (sram_rdata),
        .resp_load  (r_load),
        .resp       (r_load_data),
        .resp_busy  (r_busy)
    );

    isram_wr_ctrl isram_wr_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .req       (wr_req),
        .req_en    (wr_req_en),
        .resp_load (b_load),
        .resp      (b_load_data),
        .resp_busy (b_busy)
    );

    // R channel holding register
    resp_slot #(
        .payload_t (isram_pkg::r_payload_t)
    ) r_slot_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (r_load),
        .load_data (r_load_data),
        .busy      (r_busy),
        .valid     (rvalid),
        .ready     (rready),
        .data      (r_data)
    );

    // B channel holding register
    resp_slot #(
        .payload_t (isram_pkg::b_payload_t)
    ) b_slot_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (b_load),
        .load_data (b_load_data),
        .busy      (b_busy),
        .valid     (bvalid),
        .ready     (bready),
        .data      (b_data)
    );

    // flat axi-lite outputs
    assign rdata = r_data.data;
    assign rresp = r_data.resp;
    assign bresp = b_data.resp;

endmodule

`default_nettype wire

/* tests/isram_tb_tasks.svh */
`ifndef ISRAM_TB_TASKS_SVH
`define ISRAM_TB_TASKS_SVH

// reference copy of the memory, one entry per word
logic [`ISRAM_DATA_W-1:0] model_mem [`ISRAM_DEPTH];

// byte address inside the memory
function automatic logic in_range(input logic [`ISRAM_ADDR_W-1:0] addr);
    return addr < `ISRAM_DEPTH * 4;
endfunction

// word number, -1 when past the end
function automatic int word_of(input logic [`ISRAM_ADDR_W-1:0] addr);
    if (in_range(addr)) begin
        return int'(addr >> 2);
    end
    return -1;
endfunction

// about one address in ten lands past the end
// never picks the word the other driver holds
function automatic logic [`ISRAM_ADDR_W-1:0] pick_addr(input int avoid);
    logic [`ISRAM_ADDR_W-1:0] addr;
    do begin
        if ($urandom_range(9) == 0) begin
            addr = $urandom;
            if (in_range(addr)) begin
                addr = addr + `ISRAM_DEPTH * 4;
            end
        end else begin
            // low two bits random too, the memory ignores them
            addr = $urandom % (`ISRAM_DEPTH * 4);
        end
    end while (avoid >= 0 && word_of(addr) == avoid);
    return addr;
endfunction

// strobed update, out of range leaves the model alone
function automatic void model_apply(
    input logic [`ISRAM_ADDR_W-1:0] addr,
    input logic [`ISRAM_DATA_W-1:0] data,
    input logic [`ISRAM_STRB_W-1:0] strb
);
    if (in_range(addr)) begin
        for (int b = 0; b < `ISRAM_STRB_W; b++) begin
            if (strb[b]) begin
                model_mem[addr[`ISRAM_IDX_W+1:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    end
endfunction

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        stop_with_fail($sformatf("FAIL at %0t ns: %s is %h, expected %h",
                                 $time, name, got, exp));
    end
endtask

// one AW+W transfer, then B after bdelay cycles of back-pressure
task automatic write_txn(
    input logic [`ISRAM_ADDR_W-1:0] addr,
    input logic [`ISRAM_DATA_W-1:0] data,
    input logic [`ISRAM_STRB_W-1:0] strb,
    input int                       bdelay
);
    logic [1:0] exp_resp;
    logic [1:0] held_resp;
    exp_resp = in_range(addr) ? `ISRAM_RESP_OKAY : `ISRAM_RESP_SLVERR;
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #1;
    // both readies move as one
    while (!(awready && wready)) begin
        check_eq("wready", 32'(wready), 32'(awready));
        @(negedge clk);
        #1;
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    #1;
    while (!bvalid) begin
        @(negedge clk);
        #1;
    end
    check_eq("bresp", 32'(bresp), 32'(exp_resp));
    held_resp = bresp;
    // bready low, response must hold
    repeat (bdelay) begin
        @(negedge clk);
        #1;
        check_eq("bvalid", 32'(bvalid), 32'd1);
        check_eq("bresp", 32'(bresp), 32'(held_resp));
    end
    @(negedge clk);
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
    // B taken, the write counts from here
    model_apply(addr, data, strb);
endtask

// one AR transfer, then R after rdelay cycles of back-pressure
task automatic read_txn(input logic [`ISRAM_ADDR_W-1:0] addr, input int rdelay);
    logic [`ISRAM_DATA_W-1:0] exp_data;
    logic [1:0]               exp_resp;
    logic [`ISRAM_DATA_W-1:0] held_data;
    logic [1:0]               held_resp;
    exp_resp = in_range(addr) ? `ISRAM_RESP_OKAY : `ISRAM_RESP_SLVERR;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
        @(negedge clk);
        #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
    #1;
    // no second address while this read is open
    while (!rvalid) begin
        check_eq("arready", 32'(arready), 32'd0);
        @(negedge clk);
        #1;
    end
    // word is reserved, so the model cannot move under the read
    exp_data = in_range(addr) ? model_mem[addr[`ISRAM_IDX_W+1:2]] : `ISRAM_INST_NOP;
    check_eq("rdata", rdata, exp_data);
    check_eq("rresp", 32'(rresp), 32'(exp_resp));
    held_data = rdata;
    held_resp = rresp;
    repeat (rdelay) begin
        @(negedge clk);
        #1;
        check_eq("rvalid", 32'(rvalid), 32'd1);
        check_eq("rdata", rdata, held_data);
        check_eq("rresp", 32'(rresp), 32'(held_resp));
        check_eq("arready", 32'(arready), 32'd0);
    end
    @(negedge clk);
    rready = 1'b1;
    #1;
    check_eq("arready", 32'(arready), 32'd0);
    @(negedge clk);
    rready = 1'b0;
endtask

task automatic run_writes();
    logic [`ISRAM_ADDR_W-1:0] addr;
    for (int n = 0; n < WR_COUNT; n++) begin
        addr    = pick_addr(rd_word);
        wr_word = word_of(addr);
        write_txn(addr, $urandom, 4'($urandom_range(15)), int'($urandom_range(3)));
        wr_word = -1;
    end
endtask

task automatic run_reads();
    logic [`ISRAM_ADDR_W-1:0] addr;
    for (int n = 0; n < RD_COUNT; n++) begin
        addr    = pick_addr(wr_word);
        rd_word = word_of(addr);
        read_txn(addr, int'($urandom_range(3)));
        rd_word = -1;
    end
endtask

`endif

/* tests/isram_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "isram_defs.svh"

module isram_tb;

    // random phase sizes
    localparam int RD_COUNT  = 400;
    localparam int WR_COUNT  = 400;
    // preload writes count as transactions too
    localparam int TXN_TOTAL = `ISRAM_DEPTH + RD_COUNT + WR_COUNT;
    // 30 cycles per transaction, 4 ns period, plus reset
    localparam int WATCH_NS  = (TXN_TOTAL * 30 + 16) * 4;

    logic                       clk;
    logic                       rst_n;
    logic [`ISRAM_ADDR_W-1:0]   araddr;
    logic                       arvalid;
    logic                       arready;
    logic [`ISRAM_DATA_W-1:0]   rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
    logic                       rready;
    logic [`ISRAM_ADDR_W-1:0]   awaddr;
    logic                       awvalid;
    logic                       awready;
    logic [`ISRAM_DATA_W-1:0]   wdata;
    logic [`ISRAM_STRB_W-1:0]   wstrb;
    logic                       wvalid;
    logic                       wready;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       bready;

    // transfers seen on each channel
    int ar_seen = 0;
    int r_seen  = 0;
    int aw_seen = 0;
    int b_seen  = 0;

    // word each driver has in flight, -1 for none
    int rd_word = -1;
    int wr_word = -1;

    task automatic stop_with_fail(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopping at the first error");
    endtask

    `include "isram_tb_tasks.svh"

    isram_top isram_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // transfer counter
    // inputs settle at the falling edge, the transfer happens at the next rising edge
    always begin
        @(negedge clk);
        #1;
        if (rst_n) begin
            if (arvalid && arready) begin
                ar_seen++;
            end
            if (rvalid && rready) begin
                r_seen++;
            end
            if (awvalid && awready && wvalid && wready) begin
                aw_seen++;
            end
            if (bvalid && bready) begin
                b_seen++;
            end
        end
    end

    // hang guard
    initial begin
        #(WATCH_NS);
        stop_with_fail("watchdog expired, the DUT stopped answering a handshake");
    end

    initial begin
        void'($urandom(32'h11bf_7db4));
        rst_n   = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        // idle state straight out of reset
        check_eq("rvalid", 32'(rvalid), 32'd0);
        check_eq("bvalid", 32'(bvalid), 32'd0);
        check_eq("arready", 32'(arready), 32'd1);
        check_eq("awready", 32'(awready), 32'd0);
        check_eq("wready", 32'(wready), 32'd0);
        // every word gets a known value
        for (int i = 0; i < `ISRAM_DEPTH; i++) begin
            write_txn(32'(i * 4), $urandom, 4'hf, 0);
        end
        // both channels at once
        fork
            run_reads();
            run_writes();
        join
        @(negedge clk);
        #1;
        if (r_seen == ar_seen && b_seen == aw_seen) begin
            $display("All tests passed!");
            $finish;
        end else begin
            check_eq("r transfer count", 32'(r_seen), 32'(ar_seen));
            check_eq("b transfer count", 32'(b_seen), 32'(aw_seen));
        end
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+logic
+incdir+tests
logic/isram_pkg.sv
logic/sram_array.sv
logic/wait_lfsr.sv
logic/resp_slot.sv
logic/isram_rd_ctrl.sv
logic/isram_wr_ctrl.sv
logic/isram_top.sv
tests/isram_tb.sv

/* Makefile */
# Verilator build and run of the instruction memory testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

# the simulator exits nonzero on any failure, which fails this target
test:
	verilator --binary --timing -f sources.f --top-module isram_tb --Mdir build -o isram_sim
	./build/isram_sim

clean:
	rm -rf build
